//--- common/axi_rd_if.sv
// read-only AXI-Lite subset with OKAY responses only, plus the valid/ready fetch link
`timescale 1ns/1ps

// AR and R channels of AXI-Lite
interface axi_rd_if;
	// read address channel
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	// read data channel
	logic [31:0] rdata;
	logic        rvalid;
	logic        rready;

	// fetch unit side
	modport master (
		output araddr, arvalid, rready,
		input  arready, rvalid, rdata
	);

	// memory side
	modport slave (
		input  araddr, arvalid, rready,
		output arready, rvalid, rdata
	);
endinterface

// one fetched word and the pc it came from
interface fetch_if;
	logic        valid;
	logic        ready;
	logic [31:0] pc;
	logic [31:0] inst;

	// fetch unit
	modport producer (output valid, pc, inst, input ready);

	// fetch queue
	modport consumer (input valid, pc, inst, output ready);
endinterface

//--- common/fetch_cfg.svh
// build-time constants; memory depth must stay a power of two for the index math
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// pc right after reset
`define FETCH_RESET_PC 32'h3000_0000

// instruction memory depth in 32-bit words
// index is pc[.. : 2] modulo this depth
`define IMEM_WORDS 64

// upper bound of wait states per AXI channel
// drawn per transfer from 0 up to this value
`define IMEM_MAX_WAIT 3

// entries in the fetch queue
`define FQ_DEPTH 2

`endif

//--- common/fetch_pkg.sv
// fetch state type only; 2'b10 is not a legal state and sends the fetch unit back to idle
package fetch_pkg;

	// request/response states of the fetch unit
	// idle    no read outstanding, may start one
	// address arvalid up, waiting for arready
	// wait    rready up, waiting for rvalid
	typedef enum logic [1:0] {
		IFU_IDLE = 2'b00,
		IFU_ADDR = 2'b01,
		IFU_WAIT = 2'b11
	} ifu_state_t;

	// 2'b10 is unused
	// the fetch unit falls back to idle if it ever lands there

endpackage

//--- fetch_top.f
+incdir+common
common/fetch_pkg.sv
common/axi_rd_if.sv
ifu/ifu.sv
src/inst_rom.sv
src/fetch_queue.sv
src/fetch_top.sv
verification/tb_clock.sv
verification/fetch_assert.sv
verification/fetch_tb.sv

//--- ifu/ifu.sv
// one read outstanding at a time; redirect and exc must be single-cycle pulses, exc has priority
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module ifu (
	input  logic        clk,
	input  logic        reset,
	input  logic        redirect,
	input  logic [31:0] redirect_pc,
	input  logic        exc,
	input  logic [31:0] mtvec,
	axi_rd_if.master    mem,
	fetch_if.producer   out
);

	fetch_pkg::ifu_state_t state;

	// pc of the word in the output slot, or of the next one to fetch
	logic [31:0] pc;
	logic [31:0] pc_next;

	// bus side registers
	logic [31:0] araddr_q;
	logic        arvalid_q;
	logic        rready_q;

	// output slot
	logic        valid_q;
	logic [31:0] inst_q;

	// epoch of the current path and of the read in flight
	logic [1:0]  cur_epoch;
	logic [1:0]  req_epoch;
	logic [1:0]  epoch_next;

	logic        flush;
	logic        handover;
	logic        start;
	logic        r_done;
	logic        capture;

	assign flush    = redirect | exc;
	assign handover = valid_q & out.ready;

	// new read only when the slot is free or emptying this cycle
	assign start = (state == fetch_pkg::IFU_IDLE) & (~valid_q | handover);

	assign r_done = mem.rvalid & rready_q;

	// stale responses are drained but never land in the slot
	assign capture = (state == fetch_pkg::IFU_WAIT) & r_done &
		(req_epoch == cur_epoch) & ~flush;

	assign epoch_next = cur_epoch + {1'b0, flush};

	// exc beats redirect, both beat the sequential step
	always_comb begin
		if (exc)
			pc_next = mtvec;
		else if (redirect)
			pc_next = redirect_pc;
		else if (handover)
			pc_next = {pc[31:2] + 30'd1, 2'b00};
		else
			pc_next = pc;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `FETCH_RESET_PC;
		else
			pc <= pc_next;
	end

	// tag taken at issue, so a redirect during the address phase already marks it stale
	always_ff @(posedge clk) begin
		if (reset) begin
			cur_epoch <= 2'd0;
			req_epoch <= 2'd0;
		end else begin
			cur_epoch <= epoch_next;
			if (start)
				req_epoch <= epoch_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= fetch_pkg::IFU_IDLE;
			arvalid_q <= 1'b0;
			rready_q  <= 1'b0;
			valid_q   <= 1'b0;
		end else begin
			case (state)
				fetch_pkg::IFU_IDLE: begin
					if (start) begin
						arvalid_q <= 1'b1;
						state     <= fetch_pkg::IFU_ADDR;
					end
				end
				fetch_pkg::IFU_ADDR: begin
					// address accepted, open the data channel
					if (mem.arready) begin
						arvalid_q <= 1'b0;
						rready_q  <= 1'b1;
						state     <= fetch_pkg::IFU_WAIT;
					end
				end
				fetch_pkg::IFU_WAIT: begin
					if (r_done) begin
						rready_q <= 1'b0;
						state    <= fetch_pkg::IFU_IDLE;
					end
				end
				default: state <= fetch_pkg::IFU_IDLE;
			endcase

			// later assignments win
			if (handover)
				valid_q <= 1'b0;
			if (capture)
				valid_q <= 1'b1;
			if (flush)
				valid_q <= 1'b0;
		end
	end

	// address held from issue until the handshake
	always_ff @(posedge clk) begin
		if (start)
			araddr_q <= pc_next;
		if (capture)
			inst_q <= mem.rdata;
	end

	assign mem.araddr  = araddr_q;
	assign mem.arvalid = arvalid_q;
	assign mem.rready  = rready_q;

	assign out.valid = valid_q;
	assign out.pc    = pc;
	assign out.inst  = inst_q;

endmodule

//--- imem.hex
// one 32-bit instruction word per line in hex, word index 0 to 63 in order
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
01100893
01200913
01300993
01400a13
01500a93
01600b13
01700b93
01800c13
01900c93
01a00d13
01b00d93
01c00e13
01d00e93
01e00f13
01f00f93
02000013
02100093
02200113
02300193
02400213
02500293
02600313
02700393
02800413
02900493
02a00513
02b00593
02c00613
02d00693
02e00713
02f00793
03000813
03100893
03200913
03300993
03400a13
03500a93
03600b13
03700b93
03800c13
03900c93
03a00d13
03b00d93
03c00e13
03d00e93
03e00f13
03f00f93

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f fetch_top.f --top-module fetch_tb -o fetch_sim

status=0
out=$(./obj_dir/fetch_sim) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && grep -qx "all tests passed" <<< "$out"; then
	exit 0
fi
exit 1

//--- src/fetch_queue.sv
// pc/instruction FIFO in front of decode; flush drops every entry, including a push in the same cycle
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_queue (
	input  logic        clk,
	input  logic        reset,
	input  logic        flush,
	fetch_if.consumer   in,
	output logic        out_valid,
	input  logic        out_ready,
	output logic [31:0] out_pc,
	output logic [31:0] out_inst
);

	localparam int DEPTH = `FQ_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [31:0]      pc_mem   [DEPTH];
	logic [31:0]      inst_mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// step with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign in.ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_pc    = pc_mem[rd_ptr];
	assign out_inst  = inst_mem[rd_ptr];

	assign push = in.valid & in.ready;
	assign pop  = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			// a pop this cycle was already seen by decode
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// entry storage
	always_ff @(posedge clk) begin
		if (push) begin
			pc_mem[wr_ptr]   <= in.pc;
			inst_mem[wr_ptr] <= in.inst;
		end
	end

endmodule

//--- src/fetch_top.sv
// fetch front end top; redirect and exc are one-cycle pulses, exc wins when both arrive together
`timescale 1ns/1ps

module fetch_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        redirect,
	input  logic [31:0] redirect_pc,
	input  logic        exc,
	input  logic [31:0] mtvec,
	output logic        out_valid,
	input  logic        out_ready,
	output logic [31:0] out_pc,
	output logic [31:0] out_inst
);

	// fetch unit to memory
	axi_rd_if u_axi ();

	// fetch unit to queue
	fetch_if u_fq ();

	// either event kills the queued wrong-path words
	logic flush;
	assign flush = redirect | exc;

	ifu u_ifu (
		.clk         (clk),
		.reset       (reset),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.exc         (exc),
		.mtvec       (mtvec),
		.mem         (u_axi.master),
		.out         (u_fq.producer)
	);

	inst_rom u_rom (
		.clk   (clk),
		.reset (reset),
		.mem   (u_axi.slave)
	);

	fetch_queue u_queue (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.in        (u_fq.consumer),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_pc    (out_pc),
		.out_inst  (out_inst)
	);

endmodule

//--- src/inst_rom.sv
// read-only word memory, preloaded from imem.hex; address wraps modulo the depth, response always OKAY
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module inst_rom (
	input logic     clk,
	input logic     reset,
	axi_rd_if.slave mem
);

	localparam int IDX_W = $clog2(`IMEM_WORDS);
	localparam int CNT_W = $clog2(`IMEM_MAX_WAIT + 2);

	logic [31:0]      rom [`IMEM_WORDS];
	logic [15:0]      lfsr;
	logic             data_phase;
	logic [CNT_W-1:0] wait_cnt;
	logic [CNT_W-1:0] draw;
	logic [IDX_W-1:0] rd_idx;

	initial $readmemh("imem.hex", rom);

	// wait count for the next phase, 0 to max
	assign draw = CNT_W'(lfsr % 16'(`IMEM_MAX_WAIT + 1));

	// ready and valid open when the count runs out
	assign mem.arready = ~data_phase & (wait_cnt == '0);
	assign mem.rvalid  = data_phase & (wait_cnt == '0);
	assign mem.rdata   = rom[rd_idx];

	// x^16 + x^14 + x^13 + x^11, steps every cycle
	always_ff @(posedge clk) begin
		if (reset)
			lfsr <= 16'hace1;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			data_phase <= 1'b0;
			wait_cnt   <= '0;
		end else if (!data_phase) begin
			// address stall only counts while a request is up
			if (mem.arvalid && mem.arready) begin
				data_phase <= 1'b1;
				wait_cnt   <= draw;
			end else if (mem.arvalid && wait_cnt != '0) begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end else begin
			if (mem.rvalid && mem.rready) begin
				data_phase <= 1'b0;
				wait_cnt   <= draw;
			end else if (wait_cnt != '0) begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

	// word index from pc bits above bit 1
	always_ff @(posedge clk) begin
		if (mem.arvalid && mem.arready)
			rd_idx <= mem.araddr[IDX_W+1:2];
	end

endmodule

//--- verification/fetch_assert.sv
// checks ifu bus and slot handshakes only; expects a synchronous active-high reset at time zero
`timescale 1ns/1ps

module fetch_assert (
	input logic                  clk,
	input logic                  reset,
	input fetch_pkg::ifu_state_t state,
	input logic [31:0]           araddr,
	input logic                  arvalid,
	input logic                  arready,
	input logic                  rready,
	input logic                  valid,
	input logic                  handover,
	input logic                  redirect,
	input logic                  exc
);

	// failures so far, summed into the final count
	int fail_count = 0;

	// address request up and steady until accepted
	ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			fail_count++;
			$error("arvalid dropped or araddr changed before arready");
		end

	// data channel open only while waiting for data
	r_state: assert property (@(posedge clk) disable iff (reset)
		rready |-> state == fetch_pkg::IFU_WAIT)
		else begin
			fail_count++;
			$error("rready high outside the wait-data state");
		end

	// slot word kept until the queue takes it or a flush kills it
	slot_hold: assert property (@(posedge clk) disable iff (reset)
		valid && !handover && !redirect && !exc |=> valid)
		else begin
			fail_count++;
			$error("fetch valid dropped without a handover or flush");
		end

	// all request lines quiet once reset is seen
	reset_quiet: assert property (@(posedge clk)
		reset |=> !arvalid && !rready && !valid)
		else begin
			fail_count++;
			$error("request lines not low in the cycle after reset");
		end

endmodule

bind ifu fetch_assert u_assert (
	.clk      (clk),
	.reset    (reset),
	.state    (state),
	.araddr   (araddr_q),
	.arvalid  (arvalid_q),
	.arready  (mem.arready),
	.rready   (rready_q),
	.valid    (valid_q),
	.handover (handover),
	.redirect (redirect),
	.exc      (exc)
);

//--- verification/fetch_tb.sv
// runs from the project root so imem.hex is found; targets are word aligned, depth a power of two
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;

	localparam int NUM_POPS   = 2000;
	localparam int MAX_CYCLES = NUM_POPS * (2 * `IMEM_MAX_WAIT + 8);
	localparam int IDX_W      = $clog2(`IMEM_WORDS);
	// events spread out so the 2-bit epoch never wraps under one read
	localparam int EVENT_GAP  = 4;

	logic        clk;
	logic        reset;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        exc;
	logic [31:0] mtvec;
	logic        out_valid;
	logic        out_ready;
	logic [31:0] out_pc;
	logic [31:0] out_inst;

	// model state
	logic [31:0] imem [`IMEM_WORDS];
	logic [31:0] rnd;
	logic [31:0] exp_pc;
	int          pops;
	int          cycles;
	int          since_event;
	int          value_errors;
	int          other_errors;
	bit          timed_out;

	tb_clock #(.PERIOD_NS(8)) u_clock (.clk(clk));

	fetch_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.exc         (exc),
		.mtvec       (mtvec),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_pc      (out_pc),
		.out_inst    (out_inst)
	);

	// 13/17/5 xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			value_errors++;
			$display("Fail %0t %s expected %08h actual %08h", $time, name, expected, actual);
		end
	endtask

	// new inputs for one cycle
	task automatic drive_inputs();
		rnd = xorshift32(rnd);
		out_ready = (rnd % 100) < 70;
		redirect = 1'b0;
		exc = 1'b0;
		if (since_event >= EVENT_GAP) begin
			rnd = xorshift32(rnd);
			redirect = (rnd % 40) == 0;
			rnd = xorshift32(rnd);
			exc = (rnd % 150) == 0;
			// now and then both at once, exc has to win
			if (exc && rnd[8])
				redirect = 1'b1;
		end
		rnd = xorshift32(rnd);
		redirect_pc = {rnd[31:2], 2'b00};
		rnd = xorshift32(rnd);
		mtvec = {rnd[31:2], 2'b00};
		since_event = (redirect || exc) ? 0 : since_event + 1;
	endtask

	// what the coming edge does: pop first, then the event
	task automatic model_edge();
		logic [IDX_W-1:0] idx;
		if (out_valid && out_ready) begin
			idx = exp_pc[IDX_W+1:2];
			compare_value("out_pc", out_pc, exp_pc);
			compare_value("out_inst", out_inst, imem[idx]);
			exp_pc = exp_pc + 32'd4;
			pops++;
		end
		if (exc)
			exp_pc = mtvec;
		else if (redirect)
			exp_pc = redirect_pc;
	endtask

	initial begin
		reset = 1'b1;
		redirect = 1'b0;
		redirect_pc = 32'd0;
		exc = 1'b0;
		mtvec = 32'd0;
		out_ready = 1'b0;
		rnd = 32'h627300c6;
		exp_pc = `FETCH_RESET_PC;
		pops = 0;
		cycles = 0;
		since_event = EVENT_GAP;
		value_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		$readmemh("imem.hex", imem);

		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		compare_value("out_valid", {31'd0, out_valid}, 32'd0);

		while (pops < NUM_POPS && !timed_out) begin
			@(posedge clk);
			#1;
			drive_inputs();
			@(negedge clk);
			model_edge();
			cycles++;
			if (cycles >= MAX_CYCLES)
				timed_out = 1'b1;
		end

		if (timed_out) begin
			other_errors++;
			$display("timeout waiting for instructions");
		end
		other_errors += u_dut.u_ifu.u_assert.fail_count;
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- verification/tb_clock.sv
// free-running testbench clock, starts low, period set in whole nanoseconds
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		// half period per toggle
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule
